/* include/muladd_macros.svh */
`ifndef MULADD_MACROS_SVH
`define MULADD_MACROS_SVH

// data path
`define MULADD_DATA_W 32
`define MULADD_N_SRC  4   // words on the flow bus
`define MULADD_SEL_W  2

// address generator counters
`define MULADD_CNT_W  16

// wishbone register map
`define MULADD_ADDR_W      3
`define MULADD_REG_SEL     3'd0   // sela, selb, opcode
`define MULADD_REG_ITER    3'd1
`define MULADD_REG_PERIOD  3'd2
`define MULADD_REG_DELAY   3'd3
`define MULADD_REG_CTRL    3'd4   // w: start, r: busy/done

`endif

/* source/muladd_pkg.sv */
`include "muladd_macros.svh"

package muladd_pkg;

   // combine rules applied after the multiplier
   typedef enum logic [2:0] {
      op_mul          = 3'd0,
      op_mul_div2     = 3'd1,
      op_mul_low      = 3'd2,
      op_macc         = 3'd3,
      op_msub         = 3'd4,
      op_macc_div2    = 3'd5,
      op_macc_16q16   = 3'd6,
      op_mul_low_macc = 3'd7
   } muladd_op_e;

   // accumulation address generator
   typedef enum logic [1:0] {
      idle       = 2'd0,
      wait_delay = 2'd1,
      count      = 2'd2,
      finish     = 2'd3
   } gen_state_e;

   // unit configuration, 55 bits
   typedef struct packed {
      logic [`MULADD_SEL_W-1:0] sela;
      logic [`MULADD_SEL_W-1:0] selb;
      muladd_op_e               opcode;
      logic [`MULADD_CNT_W-1:0] iterations;
      logic [`MULADD_CNT_W-1:0] period;
      logic [`MULADD_CNT_W-1:0] delay;
   } muladd_cfg_t;

   // four source words of the datapath
   typedef struct packed {
      logic [`MULADD_N_SRC-1:0][`MULADD_DATA_W-1:0] word;
   } flow_bus_t;

endpackage

/* source/flow_sel.sv */
`timescale 1ns/1ps
`include "muladd_macros.svh"

module flow_sel (
   input  logic [`MULADD_SEL_W-1:0]         sel,
   input  muladd_pkg::flow_bus_t            flow_in,
   output logic signed [`MULADD_DATA_W-1:0] data_out
);

   localparam int N_SRC = `MULADD_N_SRC;

   always_comb begin
      // zero for selects past the last source
      if (int'(sel) < N_SRC) begin
         data_out = flow_in.word[sel];
      end else begin
         data_out = '0;
      end
   end

endmodule

/* source/mul_pipe.sv */
`timescale 1ns/1ps
`include "muladd_macros.svh"

module mul_pipe (
   input  logic                                clk,
   input  logic                                rst,
   input  logic signed [`MULADD_DATA_W-1:0]    op_a,
   input  logic signed [`MULADD_DATA_W-1:0]    op_b,
   output logic signed [2*`MULADD_DATA_W-1:0]  product
);

   logic signed [`MULADD_DATA_W-1:0]   a_q;     // stage one
   logic signed [`MULADD_DATA_W-1:0]   b_q;
   logic signed [2*`MULADD_DATA_W-1:0] prod_q;  // stage two

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         a_q    <= '0;
         b_q    <= '0;
         prod_q <= '0;
      end else begin
         a_q    <= op_a;
         b_q    <= op_b;
         prod_q <= a_q * b_q;  // full signed width
      end
   end

   assign product = prod_q;

endmodule

/* source/acc_addrgen.sv */
`timescale 1ns/1ps
`include "muladd_macros.svh"

module acc_addrgen (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     start,
   input  logic [`MULADD_CNT_W-1:0] iterations,
   input  logic [`MULADD_CNT_W-1:0] period,
   input  logic [`MULADD_CNT_W-1:0] delay,
   output logic [`MULADD_CNT_W-1:0] acc_addr,
   output logic                     active,
   output logic                     busy,
   output logic                     done
);

   muladd_pkg::gen_state_e state;
   muladd_pkg::gen_state_e state_d;
   muladd_pkg::gen_state_e run_state;

   logic [`MULADD_CNT_W-1:0] dcnt;   // delay cycles left
   logic [`MULADD_CNT_W-1:0] addr;   // position in the period
   logic [`MULADD_CNT_W-1:0] icnt;   // finished iterations
   logic                     done_q;
   logic                     last_addr;
   logic                     last_iter;

   assign last_addr = (addr == period - 1'b1);
   assign last_iter = (icnt == iterations - 1'b1);

   always_comb begin
      // nothing to count with zero iterations or period
      if ((iterations != '0) && (period != '0)) begin
         run_state = muladd_pkg::count;
      end else begin
         run_state = muladd_pkg::finish;
      end

      state_d = state;
      case (state)
         muladd_pkg::idle: begin
            if (start) begin
               state_d = (delay != '0) ? muladd_pkg::wait_delay : run_state;
            end
         end
         muladd_pkg::wait_delay: if (dcnt == '0) state_d = run_state;
         muladd_pkg::count:      if (last_addr && last_iter) state_d = muladd_pkg::finish;
         muladd_pkg::finish:     state_d = muladd_pkg::idle;
         default:                state_d = muladd_pkg::idle;
      endcase
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state  <= muladd_pkg::idle;
         dcnt   <= '0;
         addr   <= '0;
         icnt   <= '0;
         done_q <= 1'b0;
      end else begin
         state <= state_d;

         if ((state == muladd_pkg::idle) && start) begin
            done_q <= 1'b0;
            dcnt   <= delay - 1'b1;
         end else if (state == muladd_pkg::wait_delay) begin
            dcnt <= dcnt - 1'b1;
         end

         if ((state_d == muladd_pkg::count) && (state != muladd_pkg::count)) begin
            addr <= '0;
            icnt <= '0;
         end else if (state == muladd_pkg::count) begin
            if (last_addr) begin
               addr <= '0;  // next iteration
               icnt <= icnt + 1'b1;
            end else begin
               addr <= addr + 1'b1;
            end
         end

         // sticky until the next accepted start
         if (state_d == muladd_pkg::finish) done_q <= 1'b1;
      end
   end

   assign acc_addr = addr;
   assign active   = (state == muladd_pkg::count);
   assign busy     = (state != muladd_pkg::idle);
   assign done     = done_q;

endmodule

/* source/muladd_unit.sv */
`timescale 1ns/1ps
`include "muladd_macros.svh"

module muladd_unit (
   input  logic                      clk,
   input  logic                      rst,
   input  muladd_pkg::muladd_cfg_t   cfg,
   input  logic                      start,
   input  muladd_pkg::flow_bus_t     flow_in,
   output logic [`MULADD_DATA_W-1:0] flow_out,
   output logic                      busy,
   output logic                      done
);

   localparam int DW = `MULADD_DATA_W;
   localparam logic [2*DW-1:0] HI_MASK = {{DW{1'b1}}, {DW{1'b0}}};

   logic signed [DW-1:0]     op_a;
   logic signed [DW-1:0]     op_b;
   logic signed [2*DW-1:0]   product;
   logic [`MULADD_CNT_W-1:0] acc_addr;
   logic                     active;

   logic            ld_acc0;
   logic            ld_acc1;
   logic            ld_acc2;  // aligned with product
   logic [2*DW-1:0] acc;
   logic [2*DW-1:0] base;
   logic [2*DW-1:0] prod_x2;
   logic [2*DW-1:0] result;

   flow_sel i_sel_a (
      .sel      (cfg.sela),
      .flow_in  (flow_in),
      .data_out (op_a)
   );

   flow_sel i_sel_b (
      .sel      (cfg.selb),
      .flow_in  (flow_in),
      .data_out (op_b)
   );

   mul_pipe i_mul (
      .clk     (clk),
      .rst     (rst),
      .op_a    (op_a),
      .op_b    (op_b),
      .product (product)
   );

   acc_addrgen i_addrgen (
      .clk        (clk),
      .rst        (rst),
      .start      (start),
      .iterations (cfg.iterations),
      .period     (cfg.period),
      .delay      (cfg.delay),
      .acc_addr   (acc_addr),
      .active     (active),
      .busy       (busy),
      .done       (done)
   );

   // restart at the first sample of each period, and always when idle
   assign ld_acc0 = (acc_addr == '0) || !active;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         ld_acc1 <= 1'b0;
         ld_acc2 <= 1'b0;
         acc     <= '0;
      end else begin
         ld_acc1 <= ld_acc0;
         ld_acc2 <= ld_acc1;
         acc     <= result;  // every clock
      end
   end

   always_comb begin
      base    = ld_acc2 ? '0 : acc;
      prod_x2 = product << 1;
      case (cfg.opcode)
         muladd_pkg::op_mul:        result = prod_x2;
         muladd_pkg::op_mul_div2:   result = product & HI_MASK;
         muladd_pkg::op_mul_low:    result = product << DW;
         muladd_pkg::op_macc:       result = base + (prod_x2 & HI_MASK);
         muladd_pkg::op_msub:       result = base - prod_x2;
         muladd_pkg::op_macc_div2:  result = base + (product & HI_MASK);
         muladd_pkg::op_macc_16q16: result = base + {product[47:16], {DW{1'b0}}};
         default:                   result = base + (product << DW);  // mul_low_macc
      endcase
   end

   assign flow_out = result[2*DW-1:DW];

endmodule

/* source/muladd_cfg_regs.sv */
`timescale 1ns/1ps
`include "muladd_macros.svh"

module muladd_cfg_regs (
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       wb_cyc,
   input  logic                       wb_stb,
   input  logic                       wb_we,
   input  logic [`MULADD_ADDR_W-1:0]  wb_adr,
   input  logic [`MULADD_DATA_W-1:0]  wb_dat_w,
   output logic [`MULADD_DATA_W-1:0]  wb_dat_r,
   output logic                       wb_ack,
   input  logic                       busy,
   input  logic                       done,
   output muladd_pkg::muladd_cfg_t    cfg,
   output logic                       start
);

   muladd_pkg::muladd_cfg_t  cfg_q;
   logic                     ack_q;
   logic                     start_q;
   logic                     req;
   logic [`MULADD_DATA_W-1:0] rdata;
   logic [`MULADD_DATA_W-1:0] rdata_q;

   // one ack per request, never back to back
   assign req = wb_cyc && wb_stb && !ack_q;

   always_comb begin
      rdata = '0;
      case (wb_adr)
         `MULADD_REG_SEL:    rdata[6:0] = {cfg_q.opcode, cfg_q.selb, cfg_q.sela};
         `MULADD_REG_ITER:   rdata[`MULADD_CNT_W-1:0] = cfg_q.iterations;
         `MULADD_REG_PERIOD: rdata[`MULADD_CNT_W-1:0] = cfg_q.period;
         `MULADD_REG_DELAY:  rdata[`MULADD_CNT_W-1:0] = cfg_q.delay;
         `MULADD_REG_CTRL:   rdata[1:0] = {done, busy};
         default:            rdata = '0;
      endcase
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         ack_q   <= 1'b0;
         start_q <= 1'b0;
         cfg_q   <= '0;
      end else begin
         ack_q   <= req;
         start_q <= 1'b0;
         if (req && wb_we) begin
            case (wb_adr)
               `MULADD_REG_SEL: begin
                  cfg_q.sela   <= wb_dat_w[1:0];
                  cfg_q.selb   <= wb_dat_w[3:2];
                  cfg_q.opcode <= muladd_pkg::muladd_op_e'(wb_dat_w[6:4]);
               end
               `MULADD_REG_ITER:   cfg_q.iterations <= wb_dat_w[`MULADD_CNT_W-1:0];
               `MULADD_REG_PERIOD: cfg_q.period     <= wb_dat_w[`MULADD_CNT_W-1:0];
               `MULADD_REG_DELAY:  cfg_q.delay      <= wb_dat_w[`MULADD_CNT_W-1:0];
               `MULADD_REG_CTRL:   start_q          <= wb_dat_w[0];  // run pulse
               default: ;
            endcase
         end
      end
   end

   // read word captured together with ack
   always_ff @(posedge clk) begin
      if (req) rdata_q <= rdata;
   end

   assign wb_ack   = ack_q;
   assign wb_dat_r = rdata_q;
   assign cfg      = cfg_q;
   assign start    = start_q;

endmodule

/* source/muladd_top.sv */
`timescale 1ns/1ps
`include "muladd_macros.svh"

module muladd_top (
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      wb_cyc,
   input  logic                      wb_stb,
   input  logic                      wb_we,
   input  logic [`MULADD_ADDR_W-1:0] wb_adr,
   input  logic [`MULADD_DATA_W-1:0] wb_dat_w,
   output logic [`MULADD_DATA_W-1:0] wb_dat_r,
   output logic                      wb_ack,
   input  muladd_pkg::flow_bus_t     flow_in,
   output logic [`MULADD_DATA_W-1:0] flow_out
);

   muladd_pkg::muladd_cfg_t cfg;
   logic                    start;
   logic                    busy;
   logic                    done;

   muladd_cfg_regs i_regs (
      .clk      (clk),
      .rst      (rst),
      .wb_cyc   (wb_cyc),
      .wb_stb   (wb_stb),
      .wb_we    (wb_we),
      .wb_adr   (wb_adr),
      .wb_dat_w (wb_dat_w),
      .wb_dat_r (wb_dat_r),
      .wb_ack   (wb_ack),
      .busy     (busy),
      .done     (done),
      .cfg      (cfg),
      .start    (start)
   );

   muladd_unit i_unit (
      .clk      (clk),
      .rst      (rst),
      .cfg      (cfg),
      .start    (start),
      .flow_in  (flow_in),
      .flow_out (flow_out),
      .busy     (busy),
      .done     (done)
   );

endmodule

/* sim/muladd_chk.sv */
`timescale 1ns/1ps

module muladd_chk (
   input logic clk,
   input logic rst,
   input logic wb_cyc,
   input logic wb_stb,
   input logic wb_ack,
   input logic start
);

   // one ack per request
   a_ack_single: assert property (@(posedge clk) disable iff (rst) wb_ack |=> !wb_ack)
      else $error("wb_ack high for two cycles in a row");

   a_ack_req: assert property (@(posedge clk) disable iff (rst)
                               wb_ack |-> $past(wb_cyc && wb_stb))
      else $error("wb_ack without a request in the cycle before");

   a_start_pulse: assert property (@(posedge clk) disable iff (rst) start |=> !start)
      else $error("start held longer than one cycle");

endmodule

bind muladd_cfg_regs muladd_chk i_chk (
   .clk    (clk),
   .rst    (rst),
   .wb_cyc (wb_cyc),
   .wb_stb (wb_stb),
   .wb_ack (wb_ack),
   .start  (start)
);

/* sim/muladd_tb.sv */
`timescale 1ns/1ps
`include "muladd_macros.svh"

module muladd_tb;

   localparam int DW          = `MULADD_DATA_W;
   localparam int ACK_TIMEOUT = 16;
   localparam int DONE_POLLS  = 100;

   // one flow sample with the selects and load flag of its cycle
   typedef struct packed {
      muladd_pkg::flow_bus_t    flow;
      logic [`MULADD_SEL_W-1:0] sela;
      logic [`MULADD_SEL_W-1:0] selb;
      logic                     ld;
   } sample_t;

   logic                      clk;
   logic                      rst;
   logic                      wb_cyc;
   logic                      wb_stb;
   logic                      wb_we;
   logic [`MULADD_ADDR_W-1:0] wb_adr;
   logic [DW-1:0]             wb_dat_w;
   logic [DW-1:0]             wb_dat_r;
   logic                      wb_ack;
   muladd_pkg::flow_bus_t     flow_in;
   logic [DW-1:0]             flow_out;

   integer seed;
   int     flow_errs;
   int     reg_errs;
   int     op_errs;
   int     other_errs;

   muladd_pkg::muladd_cfg_t   m_cfg;      // model copy of the registers
   sample_t                   hist[$];
   logic [2*DW-1:0]           m_acc;
   bit                        run_active;
   int                        run_k;      // cycles since the start ack
   int                        run_d;
   int                        run_p;
   int                        run_ip;
   int                        run_end;    // finish cycle
   bit                        m_done;
   bit                        wr_pending;
   logic [`MULADD_ADDR_W-1:0] wr_adr;
   logic [DW-1:0]             wr_dat;
   logic [1:0]                ctrl_exp;   // {done, busy} at the read request

   muladd_top i_dut (
      .clk      (clk),
      .rst      (rst),
      .wb_cyc   (wb_cyc),
      .wb_stb   (wb_stb),
      .wb_we    (wb_we),
      .wb_adr   (wb_adr),
      .wb_dat_w (wb_dat_w),
      .wb_dat_r (wb_dat_r),
      .wb_ack   (wb_ack),
      .flow_in  (flow_in),
      .flow_out (flow_out)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   function automatic logic [2*DW-1:0] signed_product(logic [DW-1:0] a, logic [DW-1:0] b);
      logic [2*DW-1:0] ax;
      logic [2*DW-1:0] bx;
      ax = {{DW{a[DW-1]}}, a};
      bx = {{DW{b[DW-1]}}, b};
      return ax * bx;   // modulo 2^64 is the signed product
   endfunction

   function automatic logic [2*DW-1:0] combine(muladd_pkg::muladd_op_e op,
                                               logic [2*DW-1:0] p, logic [2*DW-1:0] a);
      logic [2*DW-1:0] p2;
      p2 = p << 1;
      case (op)
         muladd_pkg::op_mul:        return p2;
         muladd_pkg::op_mul_div2:   return {p[2*DW-1:DW], {DW{1'b0}}};
         muladd_pkg::op_mul_low:    return {p[DW-1:0], {DW{1'b0}}};
         muladd_pkg::op_macc:       return a + {p2[2*DW-1:DW], {DW{1'b0}}};
         muladd_pkg::op_msub:       return a - p2;
         muladd_pkg::op_macc_div2:  return a + {p[2*DW-1:DW], {DW{1'b0}}};
         muladd_pkg::op_macc_16q16: return a + {p[47:16], {DW{1'b0}}};
         default:                   return a + {p[DW-1:0], {DW{1'b0}}};
      endcase
   endfunction

   function automatic bit model_busy();
      return run_active && (run_k >= 1) && (run_k <= run_end);
   endfunction

   // first sample of each period, or outside the count phase
   function automatic bit load_flag(int k);
      bit in_count;
      in_count = run_active && (k > run_d) && (k <= run_d + run_ip);
      return !in_count || (((k - run_d - 1) % run_p) == 0);
   endfunction

   task automatic check_flow(string name, logic [DW-1:0] got, logic [DW-1:0] exp);
      if (got !== exp) begin
         $display("MISMATCH %s got %h expected %h", name, got, exp);
         flow_errs++;
      end
   endtask

   task automatic check_reg(string name, logic [DW-1:0] got, logic [DW-1:0] exp);
      if (got !== exp) begin
         $display("MISMATCH %s got %h expected %h", name, got, exp);
         reg_errs++;
      end
   endtask

   task automatic check_op(string name, muladd_pkg::muladd_op_e got,
                           muladd_pkg::muladd_op_e exp);
      if (got !== exp) begin
         $display("MISMATCH %s got %s (%h) expected %s (%h)",
                  name, got.name(), got, exp.name(), exp);
         op_errs++;
      end
   endtask

   task automatic apply_write();
      case (wr_adr)
         `MULADD_REG_SEL: begin
            m_cfg.sela   = wr_dat[1:0];
            m_cfg.selb   = wr_dat[3:2];
            m_cfg.opcode = muladd_pkg::muladd_op_e'(wr_dat[6:4]);
         end
         `MULADD_REG_ITER:   m_cfg.iterations = wr_dat[15:0];
         `MULADD_REG_PERIOD: m_cfg.period     = wr_dat[15:0];
         `MULADD_REG_DELAY:  m_cfg.delay      = wr_dat[15:0];
         `MULADD_REG_CTRL: begin
            if (wr_dat[0] && !model_busy()) begin
               run_active = 1'b1;
               run_k      = 0;
               run_d      = int'(m_cfg.delay);
               run_p      = int'(m_cfg.period);
               run_ip     = int'(m_cfg.iterations) * int'(m_cfg.period);
               run_end    = run_d + run_ip + 1;
            end
         end
         default: ;
      endcase
   endtask

   // one clock of model and flow stimulus, at the falling edge
   task automatic tick();
      sample_t         s;
      logic [2*DW-1:0] p;
      logic [2*DW-1:0] res;
      @(negedge clk);
      if (run_active) run_k++;
      if (wr_pending && wb_ack) begin
         apply_write();
         wr_pending = 1'b0;
      end
      if (run_active && run_k == 1) m_done = 1'b0;
      if (run_active && run_k == run_end) m_done = 1'b1;
      if (hist.size() == 2) begin
         s   = hist.pop_front();
         p   = signed_product(s.flow.word[s.sela], s.flow.word[s.selb]);
         res = combine(m_cfg.opcode, p, s.ld ? {2*DW{1'b0}} : m_acc);
         check_flow("flow_out", flow_out, res[2*DW-1:DW]);
         m_acc = res;
      end
      for (int i = 0; i < `MULADD_N_SRC; i++) flow_in.word[i] = $random(seed);
      s.flow = flow_in;
      s.sela = m_cfg.sela;
      s.selb = m_cfg.selb;
      s.ld   = load_flag(run_k);
      hist.push_back(s);
   endtask

   task automatic idle_cycles(int n);
      repeat (n) tick();
   endtask

   task automatic write_reg(logic [`MULADD_ADDR_W-1:0] adr, logic [DW-1:0] dat);
      int n;
      tick();
      wb_cyc     = 1'b1;
      wb_stb     = 1'b1;
      wb_we      = 1'b1;
      wb_adr     = adr;
      wb_dat_w   = dat;
      wr_adr     = adr;
      wr_dat     = dat;
      wr_pending = 1'b1;
      n = 0;
      do begin
         tick();
         n++;
      end while (!wb_ack && n < ACK_TIMEOUT);
      if (!wb_ack) begin
         $display("write to register %0d was never acknowledged", adr);
         other_errs++;
         wr_pending = 1'b0;
      end
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
   endtask

   task automatic read_reg(logic [`MULADD_ADDR_W-1:0] adr, output logic [DW-1:0] dat);
      int n;
      tick();
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = 1'b0;
      wb_adr   = adr;
      ctrl_exp = {m_done, model_busy()};
      n = 0;
      do begin
         tick();
         n++;
      end while (!wb_ack && n < ACK_TIMEOUT);
      dat = wb_dat_r;
      if (!wb_ack) begin
         $display("read of register %0d was never acknowledged", adr);
         other_errs++;
      end
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
   endtask

   task automatic readback(logic [`MULADD_ADDR_W-1:0] adr, string name);
      logic [DW-1:0] val;
      logic [DW-1:0] rd;
      val = $random(seed);
      write_reg(adr, val);
      read_reg(adr, rd);
      check_reg(name, rd, {16'd0, val[15:0]});
   endtask

   task automatic check_ctrl();
      logic [DW-1:0] rd;
      read_reg(`MULADD_REG_CTRL, rd);
      check_reg("ctrl", rd, {30'd0, ctrl_exp});
   endtask

   task automatic wait_done();
      logic [DW-1:0] rd;
      int            n;
      n = 0;
      do begin
         read_reg(`MULADD_REG_CTRL, rd);
         check_reg("ctrl", rd, {30'd0, ctrl_exp});
         n++;
      end while (!rd[1] && n < DONE_POLLS);
      if (!rd[1]) begin
         $display("done bit still low after %0d status reads", n);
         other_errs++;
      end
   endtask

   task automatic set_op(muladd_pkg::muladd_op_e op);
      logic [DW-1:0] r;
      r = $random(seed);
      write_reg(`MULADD_REG_SEL, {25'd0, op, r[3:0]});   // random selects
   endtask

   task automatic setup_run(int iter, int period, int delay);
      write_reg(`MULADD_REG_ITER, iter);
      write_reg(`MULADD_REG_PERIOD, period);
      write_reg(`MULADD_REG_DELAY, delay);
   endtask

   initial begin
      logic [DW-1:0] rd;
      logic [DW-1:0] val;
      int            i;
      seed       = 55975;
      rst        = 1'b1;
      wb_cyc     = 1'b0;
      wb_stb     = 1'b0;
      wb_we      = 1'b0;
      wb_adr     = '0;
      wb_dat_w   = '0;
      flow_in    = '0;
      m_cfg      = '0;
      m_acc      = '0;
      run_active = 1'b0;
      run_k      = 0;
      m_done     = 1'b0;
      wr_pending = 1'b0;
      flow_errs  = 0;
      reg_errs   = 0;
      op_errs    = 0;
      other_errs = 0;
      repeat (8) @(negedge clk);
      rst = 1'b0;

      for (i = 0; i < 4; i++) begin
         val = $random(seed);
         write_reg(`MULADD_REG_SEL, val);
         read_reg(`MULADD_REG_SEL, rd);
         check_reg("sel", rd, {25'd0, val[6:0]});
         check_op("opcode", muladd_pkg::muladd_op_e'(rd[6:4]),
                  muladd_pkg::muladd_op_e'(val[6:4]));
         readback(`MULADD_REG_ITER, "iterations");
         readback(`MULADD_REG_PERIOD, "period");
         readback(`MULADD_REG_DELAY, "delay");
      end

      // generator idle, so every opcode loads a zero accumulator
      for (i = 0; i < 8; i++) begin
         set_op(muladd_pkg::muladd_op_e'(i));
         idle_cycles(16);
      end

      for (i = 3; i < 8; i++) begin
         setup_run({$random(seed)} % 3 + 1, {$random(seed)} % 4 + 1, {$random(seed)} % 4);
         set_op(muladd_pkg::muladd_op_e'(i));
         write_reg(`MULADD_REG_CTRL, 32'd1);
         check_ctrl();
         wait_done();
         idle_cycles(4);
      end

      // second start in the middle of a run
      setup_run(3, 4, 2);
      set_op(muladd_pkg::op_macc);
      write_reg(`MULADD_REG_CTRL, 32'd1);
      idle_cycles(3);
      write_reg(`MULADD_REG_CTRL, 32'd1);
      check_ctrl();
      wait_done();
      idle_cycles(5);
      check_ctrl();

      setup_run(0, 3, 0);
      write_reg(`MULADD_REG_CTRL, 32'd1);
      wait_done();
      idle_cycles(10);

      $display("errors: flow %0d reg %0d opcode %0d other %0d",
               flow_errs, reg_errs, op_errs, other_errs);
      if (flow_errs + reg_errs + op_errs + other_errs == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

/* list.f */
+incdir+include
source/muladd_pkg.sv
source/flow_sel.sv
source/mul_pipe.sv
source/acc_addrgen.sv
source/muladd_unit.sv
source/muladd_cfg_regs.sv
source/muladd_top.sv
sim/muladd_chk.sv
sim/muladd_tb.sv

/* Makefile */
BIN := obj_dir/Vmuladd_tb

.PHONY: run clean

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "ALL TESTS PASSED"

$(BIN): list.f $(wildcard include/*.svh source/*.sv sim/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module muladd_tb -f list.f -o Vmuladd_tb

clean:
	rm -rf obj_dir
